// File: axil_mem_master.sv
// single-transaction AXI4-Lite master, one read or one write per mem_start.
// mem_start is ignored while busy; any non-OKAY response sets mem_err.
`timescale 1ns/100ps
`default_nettype none

module axil_mem_master
   import cadr_ctl_pkg::*, cadr_map_pkg::*;
(
   input  logic               clk,
   input  logic               rst,
   input  logic               mem_start,
   input  logic               memwr,
   input  logic [PADDR_W-1:0] paddr,
   input  logic [DATA_W-1:0]  wr_data,
   output logic               mem_done,
   output logic               mem_err,
   output logic [DATA_W-1:0]  mem_rdata,
   output logic [PADDR_W-1:0] awaddr,
   output logic               awvalid,
   input  logic               awready,
   output logic [DATA_W-1:0]  wdata,
   output logic               wvalid,
   input  logic               wready,
   input  logic [1:0]         bresp,
   input  logic               bvalid,
   output logic               bready,
   output logic [PADDR_W-1:0] araddr,
   output logic               arvalid,
   input  logic               arready,
   input  logic [DATA_W-1:0]  rdata,
   input  logic [1:0]         rresp,
   input  logic               rvalid,
   output logic               rready
);

   typedef enum logic [1:0] {
      AX_IDLE,
      AX_ADDR,
      AX_RESP
   } ax_state_e;

   ax_state_e          state;
   logic               wr_q;
   logic [PADDR_W-1:0] addr_q;
   logic [DATA_W-1:0]  wdata_q;
   logic               aw_ok;
   logic               w_ok;

   // each write channel is done once its valid has dropped or is taken now.
   assign aw_ok = ~awvalid | awready;
   assign w_ok  = ~wvalid | wready;

   always_ff @(posedge clk) begin
      if (rst) begin
         state    <= AX_IDLE;
         wr_q     <= 1'b0;
         awvalid  <= 1'b0;
         wvalid   <= 1'b0;
         arvalid  <= 1'b0;
         bready   <= 1'b0;
         rready   <= 1'b0;
         mem_done <= 1'b0;
      end else begin
         mem_done <= 1'b0;
         case (state)
            AX_IDLE: if (mem_start) begin
               wr_q    <= memwr;
               // aw and w go up together.
               awvalid <= memwr;
               wvalid  <= memwr;
               arvalid <= ~memwr;
               state   <= AX_ADDR;
            end
            AX_ADDR: if (wr_q) begin
               if (awready)
                  awvalid <= 1'b0;
               if (wready)
                  wvalid <= 1'b0;
               if (aw_ok & w_ok) begin
                  bready <= 1'b1;
                  state  <= AX_RESP;
               end
            end else if (arready) begin
               arvalid <= 1'b0;
               rready  <= 1'b1;
               state   <= AX_RESP;
            end
            AX_RESP: if (wr_q ? bvalid : rvalid) begin
               bready   <= 1'b0;
               rready   <= 1'b0;
               mem_done <= 1'b1;
               state    <= AX_IDLE;
            end
            default: state <= AX_IDLE;
         endcase
      end
   end

   // payload, held stable for the whole transaction.
   always_ff @(posedge clk) begin
      if ((state == AX_IDLE) & mem_start) begin
         addr_q  <= paddr;
         wdata_q <= wr_data;
      end
      if ((state == AX_RESP) & wr_q & bvalid)
         mem_err <= (bresp != 2'b00);
      if ((state == AX_RESP) & ~wr_q & rvalid) begin
         mem_err   <= (rresp != 2'b00);
         mem_rdata <= rdata;
      end
   end

   assign awaddr = addr_q;
   assign araddr = addr_q;
   assign wdata  = wdata_q;

endmodule

`default_nettype wire

// File: cadr_ctl_pkg.sv
// command opcodes, phase states and memory-field codes for the VMA/MD control path.
// phase_e order is the walk order of one command.
`default_nettype none

package cadr_ctl_pkg;

   // datapath word width.
   localparam int DATA_W = 32;

   // host opcodes, one command in flight at a time.
   typedef enum logic [2:0] {
      OP_LDVMA = 3'd0,
      OP_LDMD  = 3'd1,
      OP_MEMRD = 3'd2,
      OP_MEMWR = 3'd3,
      OP_WMAP  = 3'd4,
      OP_RDMAP = 3'd5,
      OP_RDMD  = 3'd6
   } cmd_op_e;

   // phase states, one per clock except memwait.
   typedef enum logic [2:0] {
      PH_DECODE  = 3'd0,
      PH_READ    = 3'd1,
      PH_WRITE   = 3'd2,
      PH_MMU     = 3'd3,
      PH_MEMWAIT = 3'd4,
      PH_FETCH   = 3'd5
   } phase_e;

   // memory-field codes, as in the micro-op mem field.
   localparam logic [1:0] MEMF_NONE = 2'b00;
   localparam logic [1:0] MEMF_RD   = 2'b01;
   localparam logic [1:0] MEMF_WR   = 2'b10;
   localparam logic [1:0] MEMF_WMAP = 2'b11;

endpackage

`default_nettype wire

// File: cadr_map_pkg.sv
// two-level map geometry: 64-entry level 1, 256-entry level 2, 256-word pages.
// level-2 entry is {access, write-permit, 14-bit page}.
`default_nettype none

package cadr_map_pkg;

   localparam int VM0_IDX_LO  = 13;
   localparam int VM0_IDX_W   = 6;
   localparam int VM0_DATA_W  = 3;
   localparam int VM1_SUB_LO  = 8;
   localparam int VM1_SUB_W   = 5;
   // level-2 index is the level-1 entry over the VMA sub-field.
   localparam int VM1_IDX_W   = VM0_DATA_W + VM1_SUB_W;
   localparam int OFFS_W      = 8;
   localparam int VM1_DATA_W  = 16;
   localparam int VM1_ACC_BIT = 15;
   localparam int VM1_WP_BIT  = 14;
   localparam int PAGE_W      = 14;
   localparam int MAPWR0_BIT  = 26;
   localparam int MAPWR1_BIT  = 25;
   localparam int PADDR_W     = 24;

endpackage

`default_nettype wire

// File: cadr_vmem.f
cadr_ctl_pkg.sv
cadr_map_pkg.sv
vma_ctl_decode.sv
mem_cycle_seq.sv
vmem_map.sv
vma_md_regs.sv
axil_mem_master.sv
cadr_vmem_top.sv
cadr_vmem_assertions.sv
tb_cadr_vmem.sv

// File: cadr_vmem_assertions.sv
// bound into cadr_vmem_top; checks are off during reset.
`timescale 1ns/100ps
`default_nettype none

module cadr_vmem_assertions
   import cadr_ctl_pkg::*, cadr_map_pkg::*;
(
   input logic               clk,
   input logic               rst,
   input logic               cmd_ready,
   input logic               rsp_valid,
   input logic               mem_start,
   input logic               awvalid,
   input logic               awready,
   input logic [PADDR_W-1:0] awaddr,
   input logic               wvalid,
   input logic               wready,
   input logic [DATA_W-1:0]  wdata,
   input logic               arvalid,
   input logic               arready,
   input logic [PADDR_W-1:0] araddr,
   input logic               bready,
   input logic               rready
);

   // valid and payload held until ready.
   a_aw_hold: assert property (@(posedge clk) disable iff (rst)
      awvalid & ~awready |=> awvalid & $stable(awaddr)) else $error("aw dropped before ready");
   a_w_hold: assert property (@(posedge clk) disable iff (rst)
      wvalid & ~wready |=> wvalid & $stable(wdata)) else $error("w dropped before ready");
   a_ar_hold: assert property (@(posedge clk) disable iff (rst)
      arvalid & ~arready |=> arvalid & $stable(araddr)) else $error("ar dropped before ready");

   // response only while busy, a single pulse, then commands are taken again.
   a_rsp_busy: assert property (@(posedge clk) disable iff (rst)
      rsp_valid |-> ~cmd_ready ##1 (cmd_ready & ~rsp_valid))
      else $error("response while accepting commands, or no accept after it");

   // a new start only on an idle bus.
   a_one_txn: assert property (@(posedge clk) disable iff (rst)
      mem_start |-> ~(awvalid | wvalid | arvalid | bready | rready))
      else $error("second transaction started while one is outstanding");

endmodule

bind cadr_vmem_top cadr_vmem_assertions i_cadr_vmem_assertions (
   .clk(clk), .rst(rst), .cmd_ready(cmd_ready), .rsp_valid(rsp_valid),
   .mem_start(mem_start), .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
   .wvalid(wvalid), .wready(wready), .wdata(wdata),
   .arvalid(arvalid), .arready(arready), .araddr(araddr),
   .bready(bready), .rready(rready)
);

`default_nettype wire

// File: cadr_vmem_top.sv
// command latched on the accepting edge; the host may change inputs afterwards.
// responses must always be taken. AXI prot is 0, all write strobes are set.
`timescale 1ns/100ps
`default_nettype none

module cadr_vmem_top
   import cadr_ctl_pkg::*, cadr_map_pkg::*;
(
   input  logic               clk,
   input  logic               rst,
   input  logic               cmd_valid,
   output logic               cmd_ready,
   input  cmd_op_e            cmd_op,
   input  logic [DATA_W-1:0]  cmd_data,
   output logic               rsp_valid,
   output logic [DATA_W-1:0]  rsp_data,
   output logic               rsp_fault,
   output logic [PADDR_W-1:0] awaddr,
   output logic [2:0]         awprot,
   output logic               awvalid,
   input  logic               awready,
   output logic [DATA_W-1:0]  wdata,
   output logic [3:0]         wstrb,
   output logic               wvalid,
   input  logic               wready,
   input  logic [1:0]         bresp,
   input  logic               bvalid,
   output logic               bready,
   output logic [PADDR_W-1:0] araddr,
   output logic [2:0]         arprot,
   output logic               arvalid,
   input  logic               arready,
   input  logic [DATA_W-1:0]  rdata,
   input  logic [1:0]         rresp,
   input  logic               rvalid,
   output logic               rready
);

   phase_e                phase;
   cmd_op_e               op_q;
   cmd_op_e               op_cur;
   logic                  cmd_accept;
   logic [DATA_W-1:0]     vma;
   logic [DATA_W-1:0]     md;
   logic [DATA_W-1:0]     map_vma;
   logic                  memrd, memwr;
   logic                  vm0rp, vm1rp, vm0wp, vm1wp;
   logic                  vmaenb, mdsel, use_md;
   logic                  vma_ld, md_load;
   logic                  perm_ok;
   logic [VM1_DATA_W-1:0] vm1_entry;
   logic [PADDR_W-1:0]    paddr;
   logic                  mem_start, mem_done, mem_err;
   logic [DATA_W-1:0]     mem_rdata;

   assign cmd_accept = cmd_valid & cmd_ready;

   // opcode held for the later phases.
   always_ff @(posedge clk) begin
      if (rst)
         op_q <= OP_LDVMA;
      else if (cmd_accept)
         op_q <= cmd_op;
   end

   // decode sees the incoming op in PH_DECODE, the held op after.
   assign op_cur  = (phase == PH_DECODE) ? cmd_op : op_q;
   assign vma_ld  = vmaenb & cmd_accept;
   // srcmap reads the map in PH_DECODE, before vma has loaded.
   assign map_vma = vma_ld ? cmd_data : vma;
   // md from the command, or from a clean bus read.
   assign md_load = (mdsel & cmd_accept) | (memrd & mem_done & ~mem_err);

   assign awprot = 3'b000;
   assign arprot = 3'b000;
   assign wstrb  = 4'b1111;

   vma_ctl_decode i_vma_ctl_decode (
      .op(op_cur), .phase(phase), .vma(map_vma),
      .wmap(), .memrd(memrd), .memwr(memwr),
      .vm0rp(vm0rp), .vm1rp(vm1rp), .vm0wp(vm0wp), .vm1wp(vm1wp),
      .vmaenb(vmaenb), .mdsel(mdsel), .use_md(use_md)
   );

   mem_cycle_seq i_mem_cycle_seq (
      .clk(clk), .rst(rst), .cmd_valid(cmd_valid), .memrd(memrd), .memwr(memwr),
      .perm_ok(perm_ok), .mem_done(mem_done), .mem_err(mem_err),
      .cmd_ready(cmd_ready), .phase(phase), .mem_start(mem_start),
      .rsp_valid(rsp_valid), .rsp_fault(rsp_fault)
   );

   vmem_map i_vmem_map (
      .clk(clk), .vma(map_vma), .md(md),
      .vm0rp(vm0rp), .vm1rp(vm1rp), .vm0wp(vm0wp), .vm1wp(vm1wp), .is_write(memwr),
      .vm1_entry(vm1_entry), .paddr(paddr), .perm_ok(perm_ok)
   );

   vma_md_regs i_vma_md_regs (
      .clk(clk), .rst(rst), .cmd_data(cmd_data), .vmaenb(vma_ld), .mdsel(mdsel),
      .md_load(md_load), .mem_rdata(mem_rdata), .use_md(use_md), .vm1_entry(vm1_entry),
      .vma(vma), .md(md), .rsp_data(rsp_data)
   );

   axil_mem_master i_axil_mem_master (
      .clk(clk), .rst(rst), .mem_start(mem_start), .memwr(memwr), .paddr(paddr),
      .wr_data(md), .mem_done(mem_done), .mem_err(mem_err), .mem_rdata(mem_rdata),
      .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
      .wdata(wdata), .wvalid(wvalid), .wready(wready),
      .bresp(bresp), .bvalid(bvalid), .bready(bready),
      .araddr(araddr), .arvalid(arvalid), .arready(arready),
      .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
   );

endmodule

`default_nettype wire

// File: mem_cycle_seq.sv
// phase sequencer. host must take rsp_valid, there is no response back-pressure.
// one bus transaction at most per command.
`timescale 1ns/100ps
`default_nettype none

module mem_cycle_seq
   import cadr_ctl_pkg::*;
(
   input  logic   clk,
   input  logic   rst,
   input  logic   cmd_valid,
   input  logic   memrd,
   input  logic   memwr,
   input  logic   perm_ok,
   input  logic   mem_done,
   input  logic   mem_err,
   output logic   cmd_ready,
   output phase_e phase,
   output logic   mem_start,
   output logic   rsp_valid,
   output logic   rsp_fault
);

   phase_e phase_nxt;
   logic   mem_op;

   assign mem_op = memrd | memwr;

   always_comb begin
      phase_nxt = phase;
      case (phase)
         PH_DECODE:  if (cmd_valid) phase_nxt = PH_READ;
         PH_READ:    phase_nxt = PH_WRITE;
         PH_WRITE:   phase_nxt = PH_MMU;
         // no permission means the bus is skipped.
         PH_MMU:     phase_nxt = (mem_op & perm_ok) ? PH_MEMWAIT : PH_FETCH;
         PH_MEMWAIT: if (mem_done) phase_nxt = PH_FETCH;
         PH_FETCH:   phase_nxt = PH_DECODE;
         default:    phase_nxt = PH_DECODE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         phase     <= PH_DECODE;
         rsp_fault <= 1'b0;
      end else begin
         phase <= phase_nxt;
         // cleared per command, set by a map or bus failure.
         if (phase == PH_DECODE)
            rsp_fault <= 1'b0;
         else if ((phase == PH_MMU) & mem_op & ~perm_ok)
            rsp_fault <= 1'b1;
         else if ((phase == PH_MEMWAIT) & mem_done & mem_err)
            rsp_fault <= 1'b1;
      end
   end

   assign cmd_ready = (phase == PH_DECODE);
   assign rsp_valid = (phase == PH_FETCH);
   // single-cycle start, last cycle of PH_MMU.
   assign mem_start = (phase == PH_MMU) & mem_op & perm_ok;

endmodule

`default_nettype wire

// File: run_cadr_vmem.sh
#!/usr/bin/env bash
# build with Verilator, run, and decide the result from the simulation output.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_cadr_vmem \
   -f cadr_vmem.f -o sim_cadr_vmem &&
./obj_dir/sim_cadr_vmem | tee /dev/stderr | grep -qF '*** PASSED ***' &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// File: tb_cadr_vmem.sv
// the AXI4-Lite slave always answers OKAY; unwritten words read back an address pattern.
// the map is set up over level-1 entries 0..3 before any map or memory read.
`timescale 1ns/100ps
`default_nettype none

module tb_cadr_vmem
   import cadr_ctl_pkg::*, cadr_map_pkg::*;
();

   // md checks, level 1, level 2, map reads, memory, faults, random.
   localparam int N_CMDS     = 3 + 8 + 128 + 10 + 8 + 6 + 200;
   localparam int MAX_CYCLES = 40 * N_CMDS;

   logic               clk = 1'b0;
   logic               rst;
   logic               cmd_valid;
   cmd_op_e            cmd_op;
   logic [DATA_W-1:0]  cmd_data;
   logic               cmd_ready;
   logic               rsp_valid;
   logic [DATA_W-1:0]  rsp_data;
   logic               rsp_fault;
   logic [PADDR_W-1:0] awaddr;
   logic [2:0]         awprot;
   logic               awvalid;
   logic               awready = 1'b0;
   logic [DATA_W-1:0]  wdata;
   logic [3:0]         wstrb;
   logic               wvalid;
   logic               wready = 1'b0;
   logic [1:0]         bresp = 2'b00;
   logic               bvalid = 1'b0;
   logic               bready;
   logic [PADDR_W-1:0] araddr;
   logic [2:0]         arprot;
   logic               arvalid;
   logic               arready = 1'b0;
   logic [DATA_W-1:0]  rdata = '0;
   logic [1:0]         rresp = 2'b00;
   logic               rvalid = 1'b0;
   logic               rready;

   int cycle_cnt = 0;
   int accept_cycle = 0;
   logic [15:0] stim_lfsr = 16'd99;
   logic [15:0] stall_lfsr = 16'd99;
   logic [32:0] exp_q [$];

   // reference model state.
   logic [DATA_W-1:0]     r_vma = '0;
   logic [DATA_W-1:0]     r_md = '0;
   logic [VM0_DATA_W-1:0] r_vm0 [2**VM0_IDX_W];
   logic [VM1_DATA_W-1:0] r_vm1 [2**VM1_IDX_W];
   logic [DATA_W-1:0]     r_mem [int];
   // slave storage, by byte address.
   logic [DATA_W-1:0]     mem [int];

   // slave bookkeeping.
   int                 aw_wait = -1;
   int                 w_wait = -1;
   int                 ar_wait = -1;
   logic               have_aw = 1'b0;
   logic               have_w = 1'b0;
   logic               aw_seen = 1'b0;
   logic               w_seen = 1'b0;
   logic               ar_seen = 1'b0;
   logic               bready_seen = 1'b0;
   logic               rready_seen = 1'b0;
   logic [PADDR_W-1:0] aw_addr_seen;
   logic [PADDR_W-1:0] ar_addr_seen;
   logic [PADDR_W-1:0] wr_addr;
   logic [DATA_W-1:0]  w_data_seen;
   logic [DATA_W-1:0]  wr_word;

   cadr_vmem_top i_cadr_vmem_top (
      .clk(clk), .rst(rst), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
      .cmd_op(cmd_op), .cmd_data(cmd_data),
      .rsp_valid(rsp_valid), .rsp_data(rsp_data), .rsp_fault(rsp_fault),
      .awaddr(awaddr), .awprot(awprot), .awvalid(awvalid), .awready(awready),
      .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
      .bresp(bresp), .bvalid(bvalid), .bready(bready),
      .araddr(araddr), .arprot(arprot), .arvalid(arvalid), .arready(arready),
      .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
   );

   always #4 clk = ~clk;

   // taps 16, 14, 13, 11.
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   function automatic logic [31:0] stim_bits(input int n);
      logic [31:0] r;
      int          k;
      r = '0;
      for (k = 0; k < n; k++) begin
         stim_lfsr = lfsr_next(stim_lfsr);
         r = {r[30:0], stim_lfsr[0]};
      end
      return r;
   endfunction

   function automatic int stall_cycles();
      int r;
      int k;
      r = 0;
      for (k = 0; k < 2; k++) begin
         stall_lfsr = lfsr_next(stall_lfsr);
         r = r * 2 + int'(stall_lfsr[0]);
      end
      return r;
   endfunction

   // pattern for words never written.
   function automatic logic [DATA_W-1:0] fill_word(input logic [PADDR_W-1:0] a);
      return {a[7:0] ^ a[23:16], a};
   endfunction

   function automatic logic [DATA_W-1:0] mk_vma(input int idx0, input int sub, input int off);
      return (idx0 << VM0_IDX_LO) | (sub << VM1_SUB_LO) | off;
   endfunction

   // level-2 entry: page j+16, no access for j%8==5, no write for j%8==6.
   function automatic logic [DATA_W-1:0] map_entry(input int j);
      logic [VM1_DATA_W-1:0] e;
      e = 16'(j + 16);
      e[VM1_ACC_BIT] = (j % 8 != 5);
      e[VM1_WP_BIT]  = (j % 8 != 6);
      return {16'h0, e};
   endfunction

   // expected {rsp_fault, rsp_data} for one command, updating the models.
   function automatic logic [32:0] ref_cmd(input cmd_op_e op, input logic [DATA_W-1:0] d);
      logic [VM0_IDX_W-1:0]  i0;
      logic [VM1_IDX_W-1:0]  i1;
      logic [VM1_DATA_W-1:0] e;
      logic [PADDR_W-1:0]    a;
      logic                  ok;
      logic                  fault;
      fault = 1'b0;
      if ((op != OP_LDMD) && (op != OP_RDMD))
         r_vma = d;
      i0 = r_vma[VM0_IDX_LO +: VM0_IDX_W];
      // level 2 is indexed by the level-1 entry before any write of this command.
      i1 = {r_vm0[i0], r_vma[VM1_SUB_LO +: VM1_SUB_W]};
      e  = r_vm1[i1];
      ok = e[VM1_ACC_BIT] & ((op != OP_MEMWR) | e[VM1_WP_BIT]);
      a  = {e[PAGE_W-1:0], r_vma[OFFS_W-1:0], 2'b00};
      case (op)
         OP_LDMD:  r_md = d;
         OP_MEMRD: begin
            if (!ok)
               fault = 1'b1;
            else
               r_md = r_mem.exists(int'(a)) ? r_mem[int'(a)] : fill_word(a);
         end
         OP_MEMWR: begin
            if (!ok)
               fault = 1'b1;
            else
               r_mem[int'(a)] = r_md;
         end
         OP_WMAP: begin
            if (d[MAPWR0_BIT])
               r_vm0[i0] = r_md[VM0_DATA_W-1:0];
            if (d[MAPWR1_BIT])
               r_vm1[i1] = r_md[VM1_DATA_W-1:0];
         end
         default: ;
      endcase
      if (op == OP_RDMAP)
         return {fault, 16'h0, e};
      return {fault, r_md};
   endfunction

   // called 1 ns after an edge, returns 1 ns after the accepting edge.
   task automatic send_cmd(input cmd_op_e op, input logic [DATA_W-1:0] d);
      cmd_valid = 1'b1;
      cmd_op    = op;
      cmd_data  = d;
      while (!cmd_ready) begin
         @(posedge clk);
         #1;
      end
      exp_q.push_back(ref_cmd(op, d));
      @(posedge clk);
      #1;
      accept_cycle = cycle_cnt;
      cmd_valid = 1'b0;
   endtask

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= MAX_CYCLES) begin
         $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
         $display("*** FAILED ***");
         $fatal(1);
      end
   end

   // AXI4-Lite slave, acting on handshakes seen at the previous edge.
   always @(posedge clk) begin
      #1;
      if (bvalid & bready_seen)
         bvalid = 1'b0;
      if (rvalid & rready_seen)
         rvalid = 1'b0;
      if (aw_seen & awready) begin
         have_aw = 1'b1;
         wr_addr = aw_addr_seen;
         aw_wait = -1;
      end
      if (w_seen & wready) begin
         have_w  = 1'b1;
         wr_word = w_data_seen;
         w_wait  = -1;
      end
      if (ar_seen & arready) begin
         rvalid  = 1'b1;
         rresp   = 2'b00;
         rdata   = mem.exists(int'(ar_addr_seen)) ? mem[int'(ar_addr_seen)]
                                                : fill_word(ar_addr_seen);
         ar_wait = -1;
      end
      if (have_aw & have_w) begin
         mem[int'(wr_addr)] = wr_word;
         bvalid  = 1'b1;
         bresp   = 2'b00;
         have_aw = 1'b0;
         have_w  = 1'b0;
      end
      // plain data accesses with full-word writes.
      if (awvalid) begin
         assert (awprot === 3'b000) else begin
            $display("Fail time=%0t awprot expected %h got %h", $time, 3'b000, awprot);
            $display("*** FAILED ***");
            $fatal(1);
         end
      end
      if (wvalid) begin
         assert (wstrb === 4'b1111) else begin
            $display("Fail time=%0t wstrb expected %h got %h", $time, 4'b1111, wstrb);
            $display("*** FAILED ***");
            $fatal(1);
         end
      end
      if (arvalid) begin
         assert (arprot === 3'b000) else begin
            $display("Fail time=%0t arprot expected %h got %h", $time, 3'b000, arprot);
            $display("*** FAILED ***");
            $fatal(1);
         end
      end
      // each ready rises after its own random wait.
      awready = 1'b0;
      if (awvalid & ~have_aw) begin
         if (aw_wait < 0)
            aw_wait = stall_cycles();
         awready = (aw_wait == 0);
         if (aw_wait > 0)
            aw_wait--;
      end
      wready = 1'b0;
      if (wvalid & ~have_w) begin
         if (w_wait < 0)
            w_wait = stall_cycles();
         wready = (w_wait == 0);
         if (w_wait > 0)
            w_wait--;
      end
      arready = 1'b0;
      if (arvalid) begin
         if (ar_wait < 0)
            ar_wait = stall_cycles();
         arready = (ar_wait == 0);
         if (ar_wait > 0)
            ar_wait--;
      end
      aw_seen      = awvalid;
      aw_addr_seen = awaddr;
      w_seen       = wvalid;
      w_data_seen  = wdata;
      ar_seen      = arvalid;
      ar_addr_seen = araddr;
      bready_seen  = bready;
      rready_seen  = rready;
   end

   // response compare, sampled mid-cycle.
   always @(negedge clk) begin
      logic [32:0] exp_w;
      if (!rst && rsp_valid) begin
         assert (exp_q.size() > 0) else begin
            $display("response arrived at %0t with no command outstanding", $time);
            $display("*** FAILED ***");
            $fatal(1);
         end
         exp_w = exp_q.pop_front();
         assert (rsp_data === exp_w[31:0]) else begin
            $display("Fail time=%0t rsp_data expected %h got %h", $time, exp_w[31:0], rsp_data);
            $display("*** FAILED ***");
            $fatal(1);
         end
         assert (rsp_fault === exp_w[32]) else begin
            $display("Fail time=%0t rsp_fault expected %b got %b", $time, exp_w[32], rsp_fault);
            $display("*** FAILED ***");
            $fatal(1);
         end
      end
   end

   initial begin
      int          i;
      int          j;
      int          prev;
      logic [31:0] v;
      logic [2:0]  ob;
      cmd_op_e     op;
      rst       = 1'b1;
      cmd_valid = 1'b0;
      cmd_op    = OP_LDVMA;
      cmd_data  = '0;
      repeat (3) @(posedge clk);
      #1;
      rst = 1'b0;

      // md load and read back, and back-to-back accept spacing.
      send_cmd(OP_LDMD, 32'h1234_5678);
      prev = accept_cycle;
      send_cmd(OP_RDMD, 32'h0);
      assert (accept_cycle - prev == 5) else begin
         $display("second command was not accepted in the fifth cycle after the first");
         $display("*** FAILED ***");
         $fatal(1);
      end
      send_cmd(OP_LDVMA, 32'hffff_0000);

      // level 1: entries 0..3 hold 0,1,0,1.
      for (i = 0; i < 4; i++) begin
         send_cmd(OP_LDMD, 32'(i % 2));
         send_cmd(OP_WMAP, (32'h1 << MAPWR0_BIT) | mk_vma(i, 0, 0));
      end
      // level 2: indices 0..63, reached through level-1 entries 0 and 1.
      for (j = 0; j < 64; j++) begin
         send_cmd(OP_LDMD, map_entry(j));
         send_cmd(OP_WMAP, (32'h1 << MAPWR1_BIT) | mk_vma(j / 32, j % 32, 0));
      end
      for (j = 0; j < 64; j += 7)
         send_cmd(OP_RDMAP, mk_vma(j / 32, j % 32, 0));

      // write then read through valid pages.
      send_cmd(OP_LDMD, 32'hdead_beef);
      send_cmd(OP_MEMWR, mk_vma(0, 1, 3));
      send_cmd(OP_LDMD, 32'h0);
      send_cmd(OP_MEMRD, mk_vma(0, 1, 3));
      send_cmd(OP_LDMD, 32'h0bad_cafe);
      send_cmd(OP_MEMWR, mk_vma(1, 1, 9));
      send_cmd(OP_MEMRD, mk_vma(0, 1, 3));
      send_cmd(OP_MEMRD, mk_vma(1, 1, 9));

      // no access, then no write permit.
      send_cmd(OP_LDMD, 32'ha5a5_a5a5);
      send_cmd(OP_MEMWR, mk_vma(0, 5, 0));
      send_cmd(OP_MEMRD, mk_vma(0, 5, 0));
      send_cmd(OP_MEMWR, mk_vma(0, 6, 2));
      send_cmd(OP_MEMRD, mk_vma(0, 6, 2));
      send_cmd(OP_RDMD, 32'h0);

      // random commands; only level-2 map writes so the index range stays set up.
      for (i = 0; i < 200; i++) begin
         ob = stim_bits(3);
         op = (ob == 3'd7) ? OP_MEMRD : cmd_op_e'(ob);
         v  = stim_bits(32);
         if ((op == OP_MEMRD) || (op == OP_MEMWR) || (op == OP_WMAP) || (op == OP_RDMAP))
            v = mk_vma(int'(stim_bits(2)), int'(stim_bits(5)), int'(stim_bits(3)));
         if (op == OP_WMAP)
            v = v | (32'h1 << MAPWR1_BIT);
         send_cmd(op, v);
      end

      while (exp_q.size() != 0) begin
         @(posedge clk);
      end
      repeat (2) @(posedge clk);
      $display("*** PASSED ***");
      $finish;
   end

endmodule

`default_nettype wire

// File: vma_ctl_decode.sv
// pure decode, no state. op must already be the live command in PH_DECODE.
// map read/write strobes follow the reference phase timing.
`timescale 1ns/100ps
`default_nettype none

module vma_ctl_decode
   import cadr_ctl_pkg::*, cadr_map_pkg::*;
(
   input  cmd_op_e           op,
   input  phase_e            phase,
   input  logic [DATA_W-1:0] vma,
   output logic              wmap,
   output logic              memrd,
   output logic              memwr,
   output logic              vm0rp,
   output logic              vm1rp,
   output logic              vm0wp,
   output logic              vm1wp,
   output logic              vmaenb,
   output logic              mdsel,
   output logic              use_md
);

   logic       destmem;
   logic       destvma;
   logic       destmdr;
   logic       loadmd;
   logic       srcmd;
   logic       srcmap;
   logic [1:0] memf;
   logic       mapwr0;
   logic       mapwr1;
   logic       early_rd;
   logic       normal_rd;

   // op to micro-op destination and source bits.
   always_comb begin
      destmem = 1'b0;
      destvma = 1'b0;
      destmdr = 1'b0;
      loadmd  = 1'b0;
      srcmd   = 1'b1;
      srcmap  = 1'b0;
      memf    = MEMF_NONE;
      case (op)
         OP_LDVMA: destvma = 1'b1;
         OP_LDMD:  destmdr = 1'b1;
         OP_MEMRD: begin
            destvma = 1'b1;
            destmem = 1'b1;
            loadmd  = 1'b1;
            memf    = MEMF_RD;
         end
         OP_MEMWR: begin
            destvma = 1'b1;
            destmem = 1'b1;
            memf    = MEMF_WR;
         end
         OP_WMAP: begin
            destvma = 1'b1;
            destmem = 1'b1;
            memf    = MEMF_WMAP;
         end
         OP_RDMAP: begin
            destvma = 1'b1;
            srcmap  = 1'b1;
            srcmd   = 1'b0;
         end
         default: srcmd = 1'b1;
      endcase
   end

   // mem field only counts when the destination is memory.
   assign {wmap, memwr, memrd} = ~destmem              ? 3'b000 :
                                 (memf == MEMF_RD)   ? 3'b001 :
                                 (memf == MEMF_WR)   ? 3'b010 :
                                 (memf == MEMF_WMAP) ? 3'b100 : 3'b000;

   // vma level bits pick which map a write goes to.
   assign mapwr0 = wmap & vma[MAPWR0_BIT];
   assign mapwr1 = wmap & vma[MAPWR1_BIT];

   // srcmap has no mmu work, so it reads the map one phase pair early.
   assign early_rd  = srcmap;
   assign normal_rd = wmap | memrd | memwr;

   assign vm0rp = ((phase == PH_DECODE) & early_rd) | ((phase == PH_WRITE) & normal_rd);
   assign vm1rp = ((phase == PH_READ) & early_rd) | ((phase == PH_MMU) & normal_rd);

   assign vm0wp = mapwr0 & (phase == PH_WRITE);
   assign vm1wp = mapwr1 & (phase == PH_MMU);

   // vma takes the command word on the accepting edge.
   assign vmaenb = destvma & (phase == PH_DECODE);

   // high selects command data into md, low selects bus read data.
   assign mdsel  = destmdr & ~loadmd & (phase == PH_DECODE);
   assign use_md = srcmd;

endmodule

`default_nettype wire

// File: vma_md_regs.sv
// VMA and MD registers, both cleared by reset.
// md_load with mdsel low takes bus read data.
`timescale 1ns/100ps
`default_nettype none

module vma_md_regs
   import cadr_ctl_pkg::*, cadr_map_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst,
   input  logic [DATA_W-1:0]     cmd_data,
   input  logic                  vmaenb,
   input  logic                  mdsel,
   input  logic                  md_load,
   input  logic [DATA_W-1:0]     mem_rdata,
   input  logic                  use_md,
   input  logic [VM1_DATA_W-1:0] vm1_entry,
   output logic [DATA_W-1:0]     vma,
   output logic [DATA_W-1:0]     md,
   output logic [DATA_W-1:0]     rsp_data
);

   always_ff @(posedge clk) begin
      if (rst) begin
         vma <= '0;
         md  <= '0;
      end else begin
         if (vmaenb)
            vma <= cmd_data;
         // command word or bus word.
         if (md_load)
            md <= mdsel ? cmd_data : mem_rdata;
      end
   end

   // srcmap returns the level-2 entry, zero extended.
   assign rsp_data = use_md ? md : {{(DATA_W-VM1_DATA_W){1'b0}}, vm1_entry};

endmodule

`default_nettype wire

// File: vmem_map.sv
// map RAMs have no reset; software writes the map before use.
// write data comes from md, address from vma.
`timescale 1ns/100ps
`default_nettype none

module vmem_map
   import cadr_ctl_pkg::*, cadr_map_pkg::*;
(
   input  logic                  clk,
   input  logic [DATA_W-1:0]     vma,
   input  logic [DATA_W-1:0]     md,
   input  logic                  vm0rp,
   input  logic                  vm1rp,
   input  logic                  vm0wp,
   input  logic                  vm1wp,
   input  logic                  is_write,
   output logic [VM1_DATA_W-1:0] vm1_entry,
   output logic [PADDR_W-1:0]    paddr,
   output logic                  perm_ok
);

   logic [VM0_DATA_W-1:0] vm0_ram [2**VM0_IDX_W];
   logic [VM1_DATA_W-1:0] vm1_ram [2**VM1_IDX_W];

   logic [VM0_IDX_W-1:0]  vm0_idx;
   logic [VM1_IDX_W-1:0]  vm1_idx;
   logic [VM0_DATA_W-1:0] vm0_q;
   logic [VM1_DATA_W-1:0] vm1_next;

   assign vm0_idx = vma[VM0_IDX_LO +: VM0_IDX_W];
   // level-1 output register chains into the level-2 index.
   assign vm1_idx = {vm0_q, vma[VM1_SUB_LO +: VM1_SUB_W]};

   // level 1, read and written in PH_WRITE (PH_DECODE for srcmap).
   always_ff @(posedge clk) begin
      if (vm0wp)
         vm0_ram[vm0_idx] <= md[VM0_DATA_W-1:0];
      if (vm0rp)
         vm0_q <= vm0_ram[vm0_idx];
   end

   // word headed for the level-2 output register.
   assign vm1_next = vm1_ram[vm1_idx];

   // level 2, read and written in PH_MMU (PH_READ for srcmap).
   always_ff @(posedge clk) begin
      if (vm1wp)
         vm1_ram[vm1_idx] <= md[VM1_DATA_W-1:0];
      if (vm1rp)
         vm1_entry <= vm1_next;
   end

   // checked ahead of the register so the sequencer can decide inside PH_MMU.
   // index is held through memwait, so this still matches the registered entry.
   assign perm_ok = vm1_next[VM1_ACC_BIT] & (~is_write | vm1_next[VM1_WP_BIT]);

   // word address to byte address.
   assign paddr = {vm1_next[PAGE_W-1:0], vma[OFFS_W-1:0], 2'b00};

endmodule

`default_nettype wire
